// File: sources.f
+incdir+verilog
verilog/rv_pkg.sv
verilog/rv_control.sv
verilog/rv_decode.sv
verilog/rv_execute.sv
verilog/rv_mem_wb.sv
verilog/rv_regs.sv
verilog/rv_core.sv
verif/tb_wb_mem.sv
verif/tb_rv_core.sv

// File: verif/tb_rv_core.sv
`timescale 1ns/1ps

`include "rv_defines.svh"

module tb_rv_core;

    localparam int CLK_HALF     = 4;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TESTS    = 9;
    localparam int PROG_WORDS   = 8;
    localparam int MEM_WORDS    = 256;
    localparam int TEST_CYCLES  = PROG_WORDS * 12;
    localparam int WATCHDOG_NS  =
        (NUM_TESTS + 1) * (TEST_CYCLES + RESET_CYCLES + 4) * 2 * CLK_HALF;

    logic          clk = 1'b0;
    logic          reset_n;
    rv_pkg::word_t wb_rdata;
    logic          wb_ack;
    rv_pkg::addr_t wb_adr;
    rv_pkg::word_t wb_wdata;
    logic          wb_we;
    logic          wb_stb;
    int            store_count;
    rv_pkg::addr_t store_adr;
    rv_pkg::word_t store_dat;

    string         t_name   [NUM_TESTS];
    rv_pkg::word_t t_prog   [NUM_TESTS * PROG_WORDS];
    rv_pkg::addr_t t_addr   [NUM_TESTS];
    rv_pkg::word_t t_data   [NUM_TESTS];
    int            t_stores [NUM_TESTS];
    int            cur_test;
    int            cur_word;
    int            test_idx;
    int            errors;
    int            passed;
    int            failed;

    always #(CLK_HALF) clk = ~clk;

    rv_core uut
    (
        .i_clk(clk), .i_reset_n(reset_n), .i_wb_dat(wb_rdata), .i_wb_ack(wb_ack),
        .o_wb_adr(wb_adr), .o_wb_dat(wb_wdata), .o_wb_we(wb_we), .o_wb_stb(wb_stb)
    );

    tb_wb_mem #(.WORDS(MEM_WORDS)) mem_model
    (
        .i_clk(clk), .i_reset_n(reset_n), .i_adr(wb_adr), .i_dat(wb_wdata),
        .i_we(wb_we), .i_stb(wb_stb), .o_dat(wb_rdata), .o_ack(wb_ack),
        .o_store_count(store_count), .o_store_adr(store_adr), .o_store_dat(store_dat)
    );

    // RV32I instruction formats
    function automatic rv_pkg::word_t rtype(input logic [6:0] f7, input int f3, input int rd,
                                            input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `RV_OPC_OP, `RV_OPC_DET};
    endfunction

    function automatic rv_pkg::word_t itype(input logic [4:0] opc, input int f3, input int rd,
                                            input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc, `RV_OPC_DET};
    endfunction

    function automatic rv_pkg::word_t stype(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `RV_OPC_STORE, `RV_OPC_DET};
    endfunction

    function automatic rv_pkg::word_t btype(input int f3, input int rs1, input int rs2,
                                            input int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                `RV_OPC_BRANCH, `RV_OPC_DET};
    endfunction

    function automatic rv_pkg::word_t utype(input logic [4:0] opc, input int rd, input int imm);
        return {imm[19:0], rd[4:0], opc, `RV_OPC_DET};
    endfunction

    function automatic rv_pkg::word_t jtype(input int rd, input int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RV_OPC_JAL, `RV_OPC_DET};
    endfunction

    // low bits 2'b10 keep a stray fetch from decoding
    function automatic rv_pkg::word_t fill_word(input rv_pkg::addr_t a);
        return a ^ 32'hA5A5_5A5A;
    endfunction

    task automatic begin_test(input string name, input rv_pkg::addr_t addr,
                              input rv_pkg::word_t data, input int stores);
        cur_test           = cur_test + 1;
        cur_word           = 0;
        t_name[cur_test]   = name;
        t_addr[cur_test]   = addr;
        t_data[cur_test]   = data;
        t_stores[cur_test] = stores;
    endtask

    task automatic emit(input rv_pkg::word_t w);
        t_prog[cur_test * PROG_WORDS + cur_word] = w;
        cur_word = cur_word + 1;
    endtask

    task automatic build_table();
        cur_test = -1;
        // unused slots spin in place
        for (int i = 0; i < NUM_TESTS * PROG_WORDS; i++)
            t_prog[i] = jtype(0, 0);

        begin_test("arith_add_sub_xor", 32'h200,
                   (32'hFFFF_FFE9 + 32'd100) ^ (32'hFFFF_FFE9 - 32'd100), 1);
        emit(itype(`RV_OPC_OP_IMM, 0, 1, 0, -23));
        emit(itype(`RV_OPC_OP_IMM, 0, 2, 0, 100));
        emit(rtype(`RV_F7_BASE, 0, 3, 1, 2));
        emit(rtype(`RV_F7_ALT, 0, 4, 1, 2));
        emit(rtype(`RV_F7_BASE, 4, 5, 3, 4));
        emit(stype(5, 0, 'h200));

        // sltu gives the shift amount of 1
        begin_test("arith_shift_sltu", 32'h204, $signed(32'hFFFF_FC18 << 1) >>> 3, 1);
        emit(itype(`RV_OPC_OP_IMM, 0, 1, 0, -1000));
        emit(itype(`RV_OPC_OP_IMM, 0, 2, 0, 3));
        emit(rtype(`RV_F7_BASE, 3, 3, 2, 1));
        emit(rtype(`RV_F7_BASE, 1, 4, 1, 3));
        emit(rtype(`RV_F7_ALT, 5, 5, 4, 2));
        emit(stype(5, 0, 'h204));

        begin_test("lui_addi", 32'h208, 32'hABCD_F000 - 32'd16, 1);
        emit(utype(`RV_OPC_LUI, 1, 'hABCDF));
        emit(itype(`RV_OPC_OP_IMM, 0, 1, 1, -16));
        emit(stype(1, 0, 'h208));

        begin_test("auipc", 32'h20C, 32'h8 + 32'h0001_0000, 1);
        emit(itype(`RV_OPC_OP_IMM, 0, 0, 0, 0));
        emit(itype(`RV_OPC_OP_IMM, 0, 0, 0, 0));
        emit(utype(`RV_OPC_AUIPC, 2, 'h00010));
        emit(stype(2, 0, 'h20C));

        // blt -7 < 9 skips the 0x666 marker
        begin_test("branch_taken", 32'h210, 32'h123, 1);
        emit(itype(`RV_OPC_OP_IMM, 0, 1, 0, -7));
        emit(itype(`RV_OPC_OP_IMM, 0, 2, 0, 9));
        emit(btype(4, 1, 2, 12));
        emit(itype(`RV_OPC_OP_IMM, 0, 3, 0, 'h666));
        emit(stype(3, 0, 'h210));
        emit(itype(`RV_OPC_OP_IMM, 0, 3, 0, 'h123));
        emit(stype(3, 0, 'h210));

        // bltu with -7 unsigned is not taken
        begin_test("branch_not_taken", 32'h214, 32'h2A5, 1);
        emit(itype(`RV_OPC_OP_IMM, 0, 1, 0, -7));
        emit(itype(`RV_OPC_OP_IMM, 0, 2, 0, 9));
        emit(btype(6, 1, 2, 12));
        emit(itype(`RV_OPC_OP_IMM, 0, 3, 0, 'h2A5));
        emit(stype(3, 0, 'h214));
        emit(itype(`RV_OPC_OP_IMM, 0, 3, 0, 'h666));
        emit(stype(3, 0, 'h214));

        // jal at 0x4 links pc + 4
        begin_test("jal_link", 32'h218, 32'h4 + 32'd4, 1);
        emit(itype(`RV_OPC_OP_IMM, 0, 0, 0, 0));
        emit(jtype(1, 12));
        emit(itype(`RV_OPC_OP_IMM, 0, 5, 0, 'h666));
        emit(stype(5, 0, 'h218));
        emit(stype(1, 0, 'h218));

        // target 19 + 1 lands on the sw of the link register
        begin_test("jalr_target", 32'h21C, 32'h4 + 32'd4, 1);
        emit(itype(`RV_OPC_OP_IMM, 0, 1, 0, 19));
        emit(itype(`RV_OPC_JALR, 0, 2, 1, 1));
        emit(itype(`RV_OPC_OP_IMM, 0, 5, 0, 'h666));
        emit(stype(5, 0, 'h21C));
        emit(stype(5, 0, 'h21C));
        emit(stype(2, 0, 'h21C));

        begin_test("load_store", 32'h224, 32'h89AB_D000 - 32'h211, 2);
        emit(utype(`RV_OPC_LUI, 1, 'h89ABD));
        emit(itype(`RV_OPC_OP_IMM, 0, 1, 1, -'h211));
        emit(stype(1, 0, 'h220));
        emit(itype(`RV_OPC_LOAD, 2, 4, 0, 'h220));
        emit(stype(4, 0, 'h224));
    endtask

    task automatic load_program(input int t);
        for (int i = 0; i < MEM_WORDS; i++)
            mem_model.mem[i] = fill_word(rv_pkg::addr_t'(i * 4));
        for (int k = 0; k < PROG_WORDS; k++)
            mem_model.mem[k] = t_prog[t * PROG_WORDS + k];
    endtask

    task automatic reset_dut(input int t);
        @(posedge clk);
        reset_n <= 1'b0;
        load_program(t);
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    endtask

    task automatic check_addr(input string name, input rv_pkg::addr_t exp,
                              input rv_pkg::addr_t act);
        if (act !== exp)
        begin
            $display("Mismatch %s: address expected %h, actual %h", name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic compare_word(input string name, input rv_pkg::word_t exp,
                                input rv_pkg::word_t act);
        if (act !== exp)
        begin
            $display("Mismatch %s: data expected %h, actual %h", name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic expect_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before)
        begin
            $display("PASS %s", name);
            passed = passed + 1;
        end
        else
        begin
            $display("FAIL %s", name);
            failed = failed + 1;
        end
    endtask

    task automatic test_reset_fetch();
        int errors_before;
        int cycles;
        errors_before = errors;
        cycles = 0;
        reset_dut(0);
        @(negedge clk);
        while (!wb_stb && (cycles < 4))
        begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (!wb_stb)
        begin
            $display("reset_vector: the core never strobed the bus after reset");
            errors = errors + 1;
        end
        else
        begin
            check_addr("reset_vector", `RV_RESET_ADDR, wb_adr);
            expect_bit("reset_vector write enable", 1'b0, wb_we);
        end
        report_test("reset_vector", errors_before);
    endtask

    task automatic run_test(input int t);
        int errors_before;
        int cycles;
        errors_before = errors;
        cycles = 0;
        reset_dut(t);
        while ((store_count < t_stores[t]) && (cycles < TEST_CYCLES))
        begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (store_count < t_stores[t])
        begin
            $display("%s: expected store did not happen within %0d cycles",
                     t_name[t], TEST_CYCLES);
            errors = errors + 1;
        end
        else
        begin
            check_addr(t_name[t], t_addr[t], store_adr);
            compare_word(t_name[t], t_data[t], store_dat);
        end
        report_test(t_name[t], errors_before);
    endtask

    initial
    begin
        reset_n  = 1'b0;
        errors   = 0;
        passed   = 0;
        failed   = 0;
        build_table();
        test_reset_fetch();
        for (test_idx = 0; test_idx < NUM_TESTS; test_idx++)
            run_test(test_idx);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 passed + failed, passed, failed, errors);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

// File: verif/tb_wb_mem.sv
`timescale 1ns/1ps

module tb_wb_mem
#(
    parameter int WORDS = 256
)
(
    input  logic          i_clk,
    input  logic          i_reset_n,
    input  rv_pkg::addr_t i_adr,
    input  rv_pkg::word_t i_dat,
    input  logic          i_we,
    input  logic          i_stb,
    output rv_pkg::word_t o_dat,
    output logic          o_ack,
    output int            o_store_count,
    output rv_pkg::addr_t o_store_adr,
    output rv_pkg::word_t o_store_dat
);

    localparam int AW = $clog2(WORDS);

    rv_pkg::word_t mem [WORDS];
    int            wait_len;
    int            wait_cnt;
    int            rng_seed;
    logic          seeded;

    initial
    begin
        o_dat         = '0;
        o_ack         = 1'b0;
        o_store_count = 0;
        rng_seed      = 32'hf888;
        seeded        = 1'b0;
    end

    // read data one cycle after the address
    always @(posedge i_clk)
    begin
        o_dat <= mem[i_adr[AW+1:2]];
    end

    // ack pulse after 0 to 2 extra wait cycles
    always @(posedge i_clk)
    begin
        // seed the wait draws once
        if (!seeded)
        begin
            rng_seed = $urandom(rng_seed);
            seeded   = 1'b1;
        end
        if (!i_reset_n || o_ack)
        begin
            o_ack    <= 1'b0;
            wait_cnt <= 0;
            wait_len <= $urandom_range(2, 0);
        end
        else if (i_stb && !i_we)
        begin
            if (wait_cnt == wait_len)
                o_ack <= 1'b1;
            else
                wait_cnt <= wait_cnt + 1;
        end
        else
        begin
            wait_cnt <= 0;
        end
    end

    // store log with the last address and data plus a running count
    always @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_store_count <= 0;
        end
        else if (i_stb && i_we)
        begin
            mem[i_adr[AW+1:2]] <= i_dat;
            o_store_count      <= o_store_count + 1;
            o_store_adr        <= i_adr;
            o_store_dat        <= i_dat;
        end
    end

endmodule

// File: verilog/rv_control.sv
`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_control
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_wb_ack,
    input  logic                i_pc_load,
    input  rv_pkg::addr_t       i_pc_target,
    output rv_pkg::core_state_t o_state,
    output rv_pkg::addr_t       o_pc
);

    rv_pkg::core_state_t state;
    rv_pkg::core_state_t state_nxt;
    rv_pkg::addr_t       pc;
    rv_pkg::addr_t       pc_nxt;

    always_comb
    begin
        case (state)
            rv_pkg::ST_FETCH:     state_nxt = i_wb_ack ? rv_pkg::ST_REG_READ : rv_pkg::ST_FETCH;
            rv_pkg::ST_REG_READ:  state_nxt = rv_pkg::ST_ALU1;
            rv_pkg::ST_ALU1:      state_nxt = rv_pkg::ST_ALU2;
            rv_pkg::ST_ALU2:      state_nxt = rv_pkg::ST_MEM;
            rv_pkg::ST_MEM:       state_nxt = rv_pkg::ST_WRITE_BACK;
            default:              state_nxt = rv_pkg::ST_FETCH;
        endcase
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            state <= rv_pkg::ST_FETCH;
        else
            state <= state_nxt;
    end

    // jump decision is only valid during the alu states
    always_ff @(posedge i_clk)
    begin
        if (state == rv_pkg::ST_ALU2)
            pc_nxt <= i_pc_load ? i_pc_target : pc + 32'd4;
    end

    // pc stays put until write-back, link value needs it
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            pc <= `RV_RESET_ADDR;
        else if (state == rv_pkg::ST_WRITE_BACK)
            pc <= pc_nxt;
    end

    assign o_state = state;
    assign o_pc    = pc;

    a_state_legal: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !$isunknown(state) && (state inside {rv_pkg::ST_FETCH, rv_pkg::ST_REG_READ,
        rv_pkg::ST_ALU1, rv_pkg::ST_ALU2, rv_pkg::ST_MEM, rv_pkg::ST_WRITE_BACK}));

    a_pc_load_alu: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_pc_load |-> (state inside {rv_pkg::ST_ALU1, rv_pkg::ST_ALU2}));

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_core
(
    input  logic          i_clk,
    input  logic          i_reset_n,
    input  rv_pkg::word_t i_wb_dat,
    input  logic          i_wb_ack,
    output rv_pkg::addr_t o_wb_adr,
    output rv_pkg::word_t o_wb_dat,
    output logic          o_wb_we,
    output logic          o_wb_stb
);

    rv_pkg::core_state_t state;
    rv_pkg::addr_t       pc;
    logic                pc_load;
    rv_pkg::addr_t       pc_target;
    rv_pkg::reg_idx_t    rs1, rs2, rd;
    rv_pkg::alu_op_t     alu_op;
    rv_pkg::op1_sel_t    op1_sel;
    rv_pkg::op2_sel_t    op2_sel;
    rv_pkg::word_t       imm_i, imm_s, imm_b, imm_u, imm_j;
    rv_pkg::jump_kind_t  jump;
    rv_pkg::res_src_t    res_src;
    logic                reg_write;
    logic                store;
    rv_pkg::word_t       rdata1, rdata2;
    rv_pkg::word_t       result;
    rv_pkg::word_t       rs2_data;
    logic                reg_we;
    rv_pkg::word_t       reg_wdata;
    rv_pkg::reg_idx_t    reg_waddr;

    rv_control u_control
    (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_wb_ack(i_wb_ack),
        .i_pc_load(pc_load), .i_pc_target(pc_target),
        .o_state(state), .o_pc(pc)
    );

    rv_decode u_decode
    (
        .i_clk(i_clk), .i_state(state), .i_wb_dat(i_wb_dat),
        .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd),
        .o_alu_op(alu_op), .o_op1_sel(op1_sel), .o_op2_sel(op2_sel),
        .o_imm_i(imm_i), .o_imm_s(imm_s), .o_imm_b(imm_b), .o_imm_u(imm_u), .o_imm_j(imm_j),
        .o_jump(jump), .o_res_src(res_src), .o_reg_write(reg_write), .o_store(store)
    );

    rv_regs u_regs
    (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_rs1(rs1), .i_rs2(rs2),
        .i_rd(reg_waddr), .i_write(reg_we), .i_data(reg_wdata),
        .o_data1(rdata1), .o_data2(rdata2)
    );

    rv_execute u_execute
    (
        .i_pc(pc), .i_rs1(rs1), .i_rs2(rs2), .i_rdata1(rdata1), .i_rdata2(rdata2),
        .i_alu_op(alu_op), .i_op1_sel(op1_sel), .i_op2_sel(op2_sel),
        .i_imm_i(imm_i), .i_imm_s(imm_s), .i_imm_b(imm_b), .i_imm_u(imm_u), .i_imm_j(imm_j),
        .i_jump(jump), .o_result(result), .o_rs2_data(rs2_data),
        .o_pc_load(pc_load), .o_pc_target(pc_target)
    );

    rv_mem_wb u_mem_wb
    (
        .i_clk(i_clk), .i_state(state), .i_pc(pc), .i_result(result),
        .i_rs2_data(rs2_data), .i_wb_dat(i_wb_dat), .i_res_src(res_src),
        .i_reg_write(reg_write), .i_store(store), .i_rd(rd),
        .o_wb_adr(o_wb_adr), .o_wb_dat(o_wb_dat), .o_wb_we(o_wb_we), .o_wb_stb(o_wb_stb),
        .o_reg_we(reg_we), .o_reg_wdata(reg_wdata), .o_reg_waddr(reg_waddr)
    );

endmodule

// File: verilog/rv_decode.sv
`timescale 1ns/1ps

`include "rv_defines.svh"

module rv_decode
(
    input  logic                i_clk,
    input  rv_pkg::core_state_t i_state,
    input  rv_pkg::word_t       i_wb_dat,
    output rv_pkg::reg_idx_t    o_rs1,
    output rv_pkg::reg_idx_t    o_rs2,
    output rv_pkg::reg_idx_t    o_rd,
    output rv_pkg::alu_op_t     o_alu_op,
    output rv_pkg::op1_sel_t    o_op1_sel,
    output rv_pkg::op2_sel_t    o_op2_sel,
    output rv_pkg::word_t       o_imm_i,
    output rv_pkg::word_t       o_imm_s,
    output rv_pkg::word_t       o_imm_b,
    output rv_pkg::word_t       o_imm_u,
    output rv_pkg::word_t       o_imm_j,
    output rv_pkg::jump_kind_t  o_jump,
    output rv_pkg::res_src_t    o_res_src,
    output logic                o_reg_write,
    output logic                o_store
);

    rv_pkg::word_t      word_buf;
    rv_pkg::word_t      word;
    logic [4:0]         opc;
    logic               det;
    rv_pkg::funct3_t    f3;
    logic               f7_base;
    logic               f7_alt;
    logic               is_load, is_store, is_opimm, is_op, is_lui;
    logic               is_auipc, is_branch, is_jal, is_jalr;
    rv_pkg::alu_op_t    alu_op;
    rv_pkg::op1_sel_t   op1_sel;
    rv_pkg::op2_sel_t   op2_sel;
    rv_pkg::res_src_t   res_src;
    rv_pkg::jump_kind_t jump;

    // read data arrives the cycle after the fetch ack
    always_ff @(posedge i_clk)
    begin
        if (i_state == rv_pkg::ST_REG_READ)
            word_buf <= i_wb_dat;
    end

    assign word    = (i_state == rv_pkg::ST_REG_READ) ? i_wb_dat : word_buf;
    assign opc     = word[6:2];
    assign det     = (word[1:0] == `RV_OPC_DET);
    assign f3      = word[14:12];
    assign f7_base = (word[31:25] == `RV_F7_BASE);
    assign f7_alt  = (word[31:25] == `RV_F7_ALT);

    assign is_load   = det && (opc == `RV_OPC_LOAD) && (f3 == 3'b010);
    assign is_store  = det && (opc == `RV_OPC_STORE) && (f3 == 3'b010);
    assign is_lui    = det && (opc == `RV_OPC_LUI);
    assign is_auipc  = det && (opc == `RV_OPC_AUIPC);
    assign is_jal    = det && (opc == `RV_OPC_JAL);
    assign is_jalr   = det && (opc == `RV_OPC_JALR) && (f3 == 3'b000);
    assign is_branch = det && (opc == `RV_OPC_BRANCH) && (f3[2:1] != 2'b01);
    assign is_opimm  = det && (opc == `RV_OPC_OP_IMM) &&
                       ((f3 == 3'b001) ? f7_base :
                        (f3 == 3'b101) ? (f7_base || f7_alt) : 1'b1);
    assign is_op     = det && (opc == `RV_OPC_OP) &&
                       (f7_base || (f7_alt && ((f3 == 3'b000) || (f3 == 3'b101))));

    always_comb
    begin
        alu_op = rv_pkg::ALU_ADD;
        if (is_branch)
        begin
            case (f3)
                3'b000:  alu_op = rv_pkg::ALU_EQ;
                3'b001:  alu_op = rv_pkg::ALU_NE;
                3'b100:  alu_op = rv_pkg::ALU_LT;
                3'b101:  alu_op = rv_pkg::ALU_GE;
                3'b110:  alu_op = rv_pkg::ALU_LTU;
                default: alu_op = rv_pkg::ALU_GEU;
            endcase
        end
        else if (is_op || is_opimm)
        begin
            case (f3)
                3'b000:  alu_op = (is_op && f7_alt) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                3'b001:  alu_op = rv_pkg::ALU_SLL;
                3'b010:  alu_op = rv_pkg::ALU_LT;
                3'b011:  alu_op = rv_pkg::ALU_LTU;
                3'b100:  alu_op = rv_pkg::ALU_XOR;
                3'b101:  alu_op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
                3'b110:  alu_op = rv_pkg::ALU_OR;
                default: alu_op = rv_pkg::ALU_AND;
            endcase
        end
    end

    always_comb
    begin
        op1_sel = (is_auipc || is_jal) ? rv_pkg::OP1_PC : rv_pkg::OP1_REG;

        if (is_jal)
            op2_sel = rv_pkg::OP2_IMM_J;
        else if (is_lui || is_auipc)
            op2_sel = rv_pkg::OP2_IMM_U;
        else if (is_jalr || is_load || is_opimm)
            op2_sel = rv_pkg::OP2_IMM_I;
        else if (is_store)
            op2_sel = rv_pkg::OP2_IMM_S;
        else
            op2_sel = rv_pkg::OP2_REG;

        if (is_load)
            res_src = rv_pkg::RES_MEM;
        else if (is_jal || is_jalr)
            res_src = rv_pkg::RES_PC_PLUS4;
        else
            res_src = rv_pkg::RES_ALU;

        if (is_branch)
            jump = rv_pkg::JUMP_BRANCH;
        else if (is_jal)
            jump = rv_pkg::JUMP_JAL;
        else if (is_jalr)
            jump = rv_pkg::JUMP_JALR;
        else
            jump = rv_pkg::JUMP_NONE;
    end

    // lui adds its immediate to x0
    assign o_rs1 = is_lui ? `RV_REG_AW'(0) : word[19:15];
    assign o_rs2 = word[24:20];

    always_ff @(posedge i_clk)
    begin
        if (i_state == rv_pkg::ST_REG_READ)
        begin
            o_rd        <= word[11:7];
            o_alu_op    <= alu_op;
            o_op1_sel   <= op1_sel;
            o_op2_sel   <= op2_sel;
            o_imm_i     <= {{(`RV_XLEN - 11){word[31]}}, word[30:20]};
            o_imm_s     <= {{21{word[31]}}, word[30:25], word[11:7]};
            o_imm_b     <= {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
            o_imm_u     <= {word[31:12], 12'b0};
            o_imm_j     <= {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
            o_jump      <= jump;
            o_res_src   <= res_src;
            o_reg_write <= is_load || is_opimm || is_op || is_lui || is_auipc ||
                           is_jal || is_jalr;
            o_store     <= is_store;
        end
        else if (i_state == rv_pkg::ST_ALU2)
        begin
            // jump request only lives through the alu states
            o_jump <= rv_pkg::JUMP_NONE;
        end
    end

endmodule

// File: verilog/rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// first fetch after reset
`define RV_RESET_ADDR   32'h0000_0000

`define RV_XLEN         32
`define RV_REG_AW       5

// low two opcode bits of every 32-bit instruction
`define RV_OPC_DET      2'b11

// major opcodes, bits [6:2]
`define RV_OPC_LOAD     5'b00000
`define RV_OPC_OP_IMM   5'b00100
`define RV_OPC_AUIPC    5'b00101
`define RV_OPC_STORE    5'b01000
`define RV_OPC_OP       5'b01100
`define RV_OPC_LUI      5'b01101
`define RV_OPC_BRANCH   5'b11000
`define RV_OPC_JALR     5'b11001
`define RV_OPC_JAL      5'b11011

// funct7 variants
`define RV_F7_BASE      7'b0000000
`define RV_F7_ALT       7'b0100000

`endif

// File: verilog/rv_execute.sv
`timescale 1ns/1ps

module rv_execute
(
    input  rv_pkg::addr_t      i_pc,
    input  rv_pkg::reg_idx_t   i_rs1,
    input  rv_pkg::reg_idx_t   i_rs2,
    input  rv_pkg::word_t      i_rdata1,
    input  rv_pkg::word_t      i_rdata2,
    input  rv_pkg::alu_op_t    i_alu_op,
    input  rv_pkg::op1_sel_t   i_op1_sel,
    input  rv_pkg::op2_sel_t   i_op2_sel,
    input  rv_pkg::word_t      i_imm_i,
    input  rv_pkg::word_t      i_imm_s,
    input  rv_pkg::word_t      i_imm_b,
    input  rv_pkg::word_t      i_imm_u,
    input  rv_pkg::word_t      i_imm_j,
    input  rv_pkg::jump_kind_t i_jump,
    output rv_pkg::word_t      o_result,
    output rv_pkg::word_t      o_rs2_data,
    output logic               o_pc_load,
    output rv_pkg::addr_t      o_pc_target
);

    rv_pkg::word_t rs1_val;
    rv_pkg::word_t rs2_val;
    rv_pkg::word_t op1;
    rv_pkg::word_t op2;
    rv_pkg::word_t op2_b;
    logic [32:0]   sum;
    logic [32:0]   shr_ext;
    logic          sub_mode;
    logic          ovf;
    logic          lt_s;
    logic          lt_u;
    logic          eq;

    assign rs1_val = (i_rs1 != '0) ? i_rdata1 : '0;
    assign rs2_val = (i_rs2 != '0) ? i_rdata2 : '0;

    assign op1 = (i_op1_sel == rv_pkg::OP1_PC) ? i_pc : rs1_val;

    always_comb
    begin
        case (i_op2_sel)
            rv_pkg::OP2_IMM_I: op2 = i_imm_i;
            rv_pkg::OP2_IMM_S: op2 = i_imm_s;
            rv_pkg::OP2_IMM_U: op2 = i_imm_u;
            rv_pkg::OP2_IMM_J: op2 = i_imm_j;
            default:           op2 = rs2_val;
        endcase
    end

    // one adder; everything but add runs it as a subtract
    assign sub_mode = (i_alu_op != rv_pkg::ALU_ADD);
    assign op2_b    = sub_mode ? ~op2 : op2;
    assign sum      = {1'b0, op1} + {1'b0, op2_b} + {32'b0, sub_mode};
    assign ovf      = (op1[31] ^ op2[31]) & (op1[31] ^ sum[31]);
    assign lt_s     = sum[31] ^ ovf;
    assign lt_u     = !sum[32];
    assign eq       = (sum[31:0] == '0);

    assign shr_ext = $signed({(i_alu_op == rv_pkg::ALU_SRA) && op1[31], op1}) >>> op2[4:0];

    always_comb
    begin
        case (i_alu_op)
            rv_pkg::ALU_XOR: o_result = op1 ^ op2;
            rv_pkg::ALU_OR:  o_result = op1 | op2;
            rv_pkg::ALU_AND: o_result = op1 & op2;
            rv_pkg::ALU_SLL: o_result = op1 << op2[4:0];
            rv_pkg::ALU_SRL: o_result = shr_ext[31:0];
            rv_pkg::ALU_SRA: o_result = shr_ext[31:0];
            rv_pkg::ALU_EQ:  o_result = {31'b0, eq};
            rv_pkg::ALU_NE:  o_result = {31'b0, !eq};
            rv_pkg::ALU_LT:  o_result = {31'b0, lt_s};
            rv_pkg::ALU_GE:  o_result = {31'b0, !lt_s};
            rv_pkg::ALU_LTU: o_result = {31'b0, lt_u};
            rv_pkg::ALU_GEU: o_result = {31'b0, !lt_u};
            default:         o_result = sum[31:0];
        endcase
    end

    assign o_rs2_data = rs2_val;

    assign o_pc_load = (i_jump == rv_pkg::JUMP_JAL) || (i_jump == rv_pkg::JUMP_JALR) ||
                       ((i_jump == rv_pkg::JUMP_BRANCH) && o_result[0]);

    always_comb
    begin
        case (i_jump)
            rv_pkg::JUMP_JALR: o_pc_target = (rs1_val + i_imm_i) & ~32'd1;
            rv_pkg::JUMP_JAL:  o_pc_target = i_pc + i_imm_j;
            default:           o_pc_target = i_pc + i_imm_b;
        endcase
    end

endmodule

// File: verilog/rv_mem_wb.sv
`timescale 1ns/1ps

module rv_mem_wb
(
    input  logic                i_clk,
    input  rv_pkg::core_state_t i_state,
    input  rv_pkg::addr_t       i_pc,
    input  rv_pkg::word_t       i_result,
    input  rv_pkg::word_t       i_rs2_data,
    input  rv_pkg::word_t       i_wb_dat,
    input  rv_pkg::res_src_t    i_res_src,
    input  logic                i_reg_write,
    input  logic                i_store,
    input  rv_pkg::reg_idx_t    i_rd,
    output rv_pkg::addr_t       o_wb_adr,
    output rv_pkg::word_t       o_wb_dat,
    output logic                o_wb_we,
    output logic                o_wb_stb,
    output logic                o_reg_we,
    output rv_pkg::word_t       o_reg_wdata,
    output rv_pkg::reg_idx_t    o_reg_waddr
);

    rv_pkg::word_t mem_result;
    rv_pkg::word_t mem_rs2;

    always_ff @(posedge i_clk)
    begin
        if (i_state == rv_pkg::ST_ALU2)
        begin
            mem_result <= i_result;
            mem_rs2    <= i_rs2_data;
        end
    end

    // memory address only in the mem state, pc otherwise
    assign o_wb_adr = (i_state == rv_pkg::ST_MEM) ? mem_result : i_pc;
    assign o_wb_dat = mem_rs2;
    assign o_wb_we  = (i_state == rv_pkg::ST_MEM) && i_store;
    assign o_wb_stb = (i_state == rv_pkg::ST_FETCH) || (i_state == rv_pkg::ST_MEM);

    assign o_reg_we    = (i_state == rv_pkg::ST_WRITE_BACK) && i_reg_write;
    assign o_reg_waddr = i_rd;

    // load data shows up in write-back
    always_comb
    begin
        case (i_res_src)
            rv_pkg::RES_MEM:      o_reg_wdata = i_wb_dat;
            rv_pkg::RES_PC_PLUS4: o_reg_wdata = i_pc + 32'd4;
            default:              o_reg_wdata = mem_result;
        endcase
    end

    a_we_in_mem: assert property (@(posedge i_clk)
        o_wb_we |-> (i_state == rv_pkg::ST_MEM) ##1 (i_state == rv_pkg::ST_WRITE_BACK));

endmodule

// File: verilog/rv_pkg.sv
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [2:0]  funct3_t;

    typedef enum logic [4:0]
    {
        ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
    } alu_op_t;

    typedef enum logic { OP1_REG, OP1_PC } op1_sel_t;

    typedef enum logic [2:0]
    {
        OP2_REG, OP2_IMM_I, OP2_IMM_S, OP2_IMM_U, OP2_IMM_J
    } op2_sel_t;

    typedef enum logic [1:0] { RES_ALU, RES_MEM, RES_PC_PLUS4 } res_src_t;

    typedef enum logic [1:0]
    {
        JUMP_NONE, JUMP_BRANCH, JUMP_JAL, JUMP_JALR
    } jump_kind_t;

    // one instruction walks through all six
    typedef enum logic [2:0]
    {
        ST_FETCH, ST_REG_READ, ST_ALU1, ST_ALU2, ST_MEM, ST_WRITE_BACK
    } core_state_t;

endpackage

// File: verilog/rv_regs.sv
`timescale 1ns/1ps

module rv_regs
(
    input  logic             i_clk,
    input  logic             i_reset_n,
    input  rv_pkg::reg_idx_t i_rs1,
    input  rv_pkg::reg_idx_t i_rs2,
    input  rv_pkg::reg_idx_t i_rd,
    input  logic             i_write,
    input  rv_pkg::word_t    i_data,
    output rv_pkg::word_t    o_data1,
    output rv_pkg::word_t    o_data2
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_write && (i_rd != '0))
        begin
            regs[i_rd] <= i_data;
        end
    end

    // registered read, data valid the cycle after the index
    always_ff @(posedge i_clk)
    begin
        o_data1 <= regs[i_rs1];
        o_data2 <= regs[i_rs2];
    end

endmodule
